//--- common/wbuf_config.svh
// memory subsystem configuration
// widths, buffer depth and bank geometry shared by all blocks
`ifndef WBUF_CONFIG_SVH
`define WBUF_CONFIG_SVH

//////////////////////////////
// data path

// address and data width
`define WBUF_XLEN 32

//////////////////////////////
// write buffer

// fifo entries, rounded up to a power of two in the buffer
`define WBUF_DEPTH 8

//////////////////////////////
// bank array

`define WBUF_BANKS 4  // power of two
`define WBUF_ROWS 64  // words per bank, power of two

`endif

//--- common/wbuf_pkg.sv
// shared types for the memory subsystem
// word, byte enable, privilege and bank addressing vectors
`include "wbuf_config.svh"

package wbuf_pkg;

  //////////////////////////////
  // data path vectors

  typedef logic [`WBUF_XLEN-1:0]   word_t;  // address or data word
  typedef logic [`WBUF_XLEN/8-1:0] be_t;    // one bit per byte

  // privilege level, 3 is machine
  typedef logic [1:0] prv_t;

  //////////////////////////////
  // bank addressing

  // bank number, taken right above the byte offset
  typedef logic [$clog2(`WBUF_BANKS)-1:0] bank_idx_t;

  // row inside a bank, msb marks the protected half
  typedef logic [$clog2(`WBUF_ROWS)-1:0] row_idx_t;

  // dispatcher states
  typedef enum logic {
    BANK_IDLE,  // nothing in flight
    BANK_BUSY   // waiting for bank ack
  } bank_fsm_t;

endpackage

//--- write_buffer/write_buffer.sv
// in-order write buffer on the cpu data port
// writes are acked at once, reads wait for the banks, flushes queue in order
`include "wbuf_config.svh"

module write_buffer import wbuf_pkg::*; (
  input  logic  clk,
  input  logic  rstn,

  // cpu side
  input  logic  mem_req,
  input  logic  mem_we,
  input  word_t mem_adr,
  input  word_t mem_d,
  input  be_t   mem_be,
  input  prv_t  st_prv,
  input  logic  bu_cacheflush,
  output word_t mem_q,
  output logic  mem_ack,

  // toward the bank dispatcher
  output logic  cache_req,
  output word_t cache_adr,
  output logic  cache_we,
  output word_t cache_d,
  output be_t   cache_be,
  output prv_t  cache_prv,
  output logic  cache_flush,
  input  word_t cache_q,
  input  logic  cache_ack
);

  localparam int FIFO_DEPTH = 2 ** $clog2(`WBUF_DEPTH);
  localparam int PTR_W      = $clog2(FIFO_DEPTH);

  //////////////////////////////
  // fifo storage, entry 0 is the head

  word_t ent_adr   [FIFO_DEPTH];
  word_t ent_d     [FIFO_DEPTH];
  be_t   ent_be    [FIFO_DEPTH];
  logic  ent_we    [FIFO_DEPTH];
  logic  ent_acked [FIFO_DEPTH];  // write already acked to cpu
  prv_t  ent_prv   [FIFO_DEPTH];
  logic  ent_flush [FIFO_DEPTH];  // flush forwarded in order

  logic [PTR_W-1:0] fifo_wadr;    // next free slot, wraps to 0 when full
  logic [PTR_W-1:0] push_idx;
  logic             fifo_we;
  logic             fifo_re;
  logic             fifo_empty;
  logic             fifo_full;

  // control
  logic we_ack;          // write accepted this cycle
  logic mem_we_ack;      // delayed write ack
  logic read_pending;    // cpu waits on a read
  logic access_pending;  // request in flight at the banks
  logic issue_acked;     // in-flight access was acked earlier

  // push when something is in flight, unless it drains this very cycle
  assign fifo_we  = access_pending & mem_req & ~(fifo_empty & cache_ack);
  assign fifo_re  = cache_ack & ~fifo_empty;  // head issued on every ack
  assign push_idx = fifo_re ? fifo_wadr - 1'b1 : fifo_wadr;

  // write pointer
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fifo_wadr <= '0;
    end else begin
      case ({fifo_we, fifo_re})
        2'b10:   fifo_wadr <= fifo_wadr + 1'b1;
        2'b01:   fifo_wadr <= fifo_wadr - 1'b1;
        default: ;
      endcase
    end
  end

  // shift down on pop, push lands at the pointer
  always_ff @(posedge clk) begin
    if (fifo_re) begin
      for (int n = 0; n < FIFO_DEPTH - 1; n++) begin
        ent_adr[n]   <= ent_adr[n+1];
        ent_d[n]     <= ent_d[n+1];
        ent_be[n]    <= ent_be[n+1];
        ent_we[n]    <= ent_we[n+1];
        ent_acked[n] <= ent_acked[n+1];
        ent_prv[n]   <= ent_prv[n+1];
        ent_flush[n] <= ent_flush[n+1];
      end
    end
    if (fifo_we) begin  // wins over the shift at the same slot
      ent_adr[push_idx]   <= mem_adr;
      ent_d[push_idx]     <= mem_d;
      ent_be[push_idx]    <= mem_be;
      ent_we[push_idx]    <= mem_we;
      ent_acked[push_idx] <= we_ack;
      ent_prv[push_idx]   <= st_prv;
      ent_flush[push_idx] <= bu_cacheflush;
    end
  end

  // full and empty flags
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fifo_full  <= 1'b0;
      fifo_empty <= 1'b1;
    end else begin
      case ({fifo_we, fifo_re})
        2'b10: begin
          fifo_full  <= &fifo_wadr;  // last slot taken
          fifo_empty <= 1'b0;
        end
        2'b01: begin
          fifo_full  <= 1'b0;
          fifo_empty <= (fifo_wadr == PTR_W'(1));
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // cpu acknowledge

  assign we_ack = mem_req & mem_we & ~read_pending;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      read_pending   <= 1'b0;
      mem_we_ack     <= 1'b0;
      access_pending <= 1'b0;
      issue_acked    <= 1'b0;
    end else begin
      read_pending   <= (read_pending & ~mem_ack) | (mem_req & ~mem_we);
      mem_we_ack     <= we_ack;
      access_pending <= cache_req | (access_pending & ~cache_ack);
      if (cache_req) begin
        issue_acked <= fifo_empty ? we_ack : ent_acked[0];  // flag of what goes out
      end
    end
  end

  // full buffer holds back the last write's ack until an entry moves
  assign mem_ack = (~fifo_full & mem_we_ack) |
                   (fifo_full & fifo_re & ent_we[FIFO_DEPTH-1]) |
                   (cache_ack & ~issue_acked);
  assign mem_q   = cache_q;

  //////////////////////////////
  // cache side, head entry or cpu bypass

  assign cache_req   = ~access_pending ? mem_req : (mem_req | ~fifo_empty) & cache_ack;
  assign cache_adr   = ~fifo_empty ? ent_adr[0]   : mem_adr;
  assign cache_we    = ~fifo_empty ? ent_we[0]    : mem_we;
  assign cache_d     = ~fifo_empty ? ent_d[0]     : mem_d;
  assign cache_be    = ~fifo_empty ? ent_be[0]    : mem_be;
  assign cache_prv   = ~fifo_empty ? ent_prv[0]   : st_prv;
  assign cache_flush = ~fifo_empty ? ent_flush[0] : bu_cacheflush;

endmodule

//--- source/bank_dispatch.sv
// bank dispatcher
// steers each access to the bank picked by its address, tracks the bank in flight
`include "wbuf_config.svh"

module bank_dispatch import wbuf_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,

  // from write buffer
  input  logic                   cache_req,
  input  word_t                  cache_adr,
  input  logic                   cache_we,
  input  word_t                  cache_d,
  input  be_t                    cache_be,
  input  prv_t                   cache_prv,
  input  logic                   cache_flush,
  input  logic                   cache_ack,

  // to bank array
  output logic [`WBUF_BANKS-1:0] bank_req,
  output logic                   bank_we,
  output row_idx_t               bank_row,
  output word_t                  bank_d,
  output be_t                    bank_be,
  output prv_t                   bank_prv,
  output logic                   bank_flush,
  output bank_idx_t              busy_bank   // for the collector
);

  localparam int BANK_W = $bits(bank_idx_t);
  localparam int ROW_W  = $bits(row_idx_t);

  bank_idx_t req_bank;
  bank_fsm_t state;

  // address map: byte offset, bank, row, rest aliases
  assign req_bank = cache_adr[2 +: BANK_W];
  assign bank_row = cache_adr[2 + BANK_W +: ROW_W];

  // one-hot request, only in the request cycle
  always_comb begin
    bank_req = '0;
    if (cache_req) begin
      bank_req[req_bank] = 1'b1;
    end
  end

  // shared attributes go to every bank
  assign bank_we    = cache_we;
  assign bank_d     = cache_d;
  assign bank_be    = cache_be;
  assign bank_prv   = cache_prv;
  assign bank_flush = cache_flush;

  //////////////////////////////
  // in-flight tracking

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= BANK_IDLE;
      busy_bank <= '0;
    end else begin
      case (state)
        BANK_IDLE: begin
          if (cache_req) begin
            state     <= BANK_BUSY;
            busy_bank <= req_bank;
          end
        end
        BANK_BUSY: begin
          if (cache_req) begin
            busy_bank <= req_bank;  // back-to-back, stay busy
          end else if (cache_ack) begin
            state <= BANK_IDLE;
          end
        end
        default: state <= BANK_IDLE;
      endcase
    end
  end

endmodule

//--- source/mem_bank.sv
// one memory bank, byte-enabled word ram
// fixed one-cycle ack, upper half writable at machine level only
`include "wbuf_config.svh"

module mem_bank import wbuf_pkg::*; (
  input  logic     clk,
  input  logic     rstn,
  input  logic     bank_req,
  input  logic     bank_we,
  input  row_idx_t bank_row,
  input  word_t    bank_d,
  input  be_t      bank_be,
  input  prv_t     bank_prv,
  input  logic     bank_flush,
  output logic     bank_ack,
  output word_t    bank_q
);

  localparam prv_t PRV_M = prv_t'(3);  // machine level

  word_t mem [`WBUF_ROWS];

  word_t merged;     // row with enabled bytes replaced
  logic  protect;    // row in upper half
  logic  do_write;

  assign protect  = bank_row[$bits(row_idx_t)-1];

  // flush never touches storage
  assign do_write = bank_req & bank_we & ~bank_flush &
                    (~protect | (bank_prv == PRV_M));

  // byte merge
  always_comb begin
    merged = mem[bank_row];
    for (int b = 0; b < $bits(be_t); b++) begin
      if (bank_be[b]) begin
        merged[b*8 +: 8] = bank_d[b*8 +: 8];
      end
    end
  end

  //////////////////////////////
  // storage and read port

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[bank_row] <= merged;
    end
    if (bank_req) begin
      bank_q <= do_write ? merged : mem[bank_row];  // row after the update
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      bank_ack <= 1'b0;
    end else begin
      bank_ack <= bank_req;  // every request, one cycle
    end
  end

endmodule

//--- source/resp_collect.sv
// response collector
// merges bank acks and returns the answering bank's data to the buffer
`include "wbuf_config.svh"

module resp_collect import wbuf_pkg::*; (
  input  logic [`WBUF_BANKS-1:0] bank_ack,
  input  word_t                  bank_q [`WBUF_BANKS],
  input  bank_idx_t              busy_bank,
  output logic                   cache_ack,
  output word_t                  cache_q
);

  logic hit;  // bank in flight is answering

  // only one bank can answer at a time
  assign cache_ack = |bank_ack;
  assign hit       = bank_ack[busy_bank];

  // zero data when nobody answers
  always_comb begin
    cache_q = '0;
    if (hit) begin
      cache_q = bank_q[busy_bank];
    end
  end

endmodule

//--- source/mem_subsys_top.sv
// memory subsystem top
// write buffer, dispatcher, bank array and response collector
`include "wbuf_config.svh"

module mem_subsys_top import wbuf_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  mem_req,
  input  logic  mem_we,
  input  word_t mem_adr,
  input  word_t mem_d,
  input  be_t   mem_be,
  input  prv_t  st_prv,
  input  logic  bu_cacheflush,
  output word_t mem_q,
  output logic  mem_ack
);

  // buffer to dispatcher
  logic  cache_req;
  word_t cache_adr;
  logic  cache_we;
  word_t cache_d;
  be_t   cache_be;
  prv_t  cache_prv;
  logic  cache_flush;
  logic  cache_ack;
  word_t cache_q;

  // dispatcher to banks
  logic [`WBUF_BANKS-1:0] bank_req;
  logic                   bank_we;
  row_idx_t               bank_row;
  word_t                  bank_d;
  be_t                    bank_be;
  prv_t                   bank_prv;
  logic                   bank_flush;
  bank_idx_t              busy_bank;

  // banks to collector
  logic [`WBUF_BANKS-1:0] bank_ack;
  word_t                  bank_q [`WBUF_BANKS];

  write_buffer u_wbuf (
    .clk, .rstn, .mem_req, .mem_we, .mem_adr, .mem_d, .mem_be, .st_prv,
    .bu_cacheflush, .mem_q, .mem_ack,
    .cache_req, .cache_adr, .cache_we, .cache_d, .cache_be, .cache_prv,
    .cache_flush, .cache_q, .cache_ack
  );

  bank_dispatch u_disp (
    .clk, .rstn, .cache_req, .cache_adr, .cache_we, .cache_d, .cache_be,
    .cache_prv, .cache_flush, .cache_ack,
    .bank_req, .bank_we, .bank_row, .bank_d, .bank_be, .bank_prv,
    .bank_flush, .busy_bank
  );

  //////////////////////////////
  // bank array

  for (genvar g = 0; g < `WBUF_BANKS; g++) begin : g_bank
    mem_bank u_bank (
      .clk, .rstn,
      .bank_req (bank_req[g]),
      .bank_we, .bank_row, .bank_d, .bank_be, .bank_prv, .bank_flush,
      .bank_ack (bank_ack[g]),
      .bank_q   (bank_q[g])
    );
  end

  resp_collect u_coll (
    .bank_ack, .bank_q, .busy_bank, .cache_ack, .cache_q
  );

endmodule

//--- testbench/mem_checker.sv
// cpu port checker for the memory subsystem
// shadow memory by bank and row, compares read data and write ack timing
`include "wbuf_config.svh"

module mem_checker import wbuf_pkg::*; (
  input  logic  clk,
  input  logic  rstn,
  input  logic  mem_req,
  input  logic  mem_we,
  input  word_t mem_adr,
  input  word_t mem_d,
  input  be_t   mem_be,
  input  prv_t  st_prv,
  input  logic  bu_cacheflush,
  input  word_t mem_q,
  input  logic  mem_ack,
  output int    err_cnt,
  output int    pend_cnt
);

  localparam int   BANK_W = $bits(bank_idx_t);
  localparam int   ROW_W  = $bits(row_idx_t);
  localparam prv_t PRV_M  = prv_t'(3);

  word_t shadow [`WBUF_BANKS][`WBUF_ROWS];

  // outstanding requests, oldest first
  int    req_cycle [$];
  logic  req_write [$];
  logic  req_check [$];  // plain read, data compared
  word_t req_exp   [$];
  int    cycle;

  // expected row contents after one access
  function automatic word_t ref_word(input word_t old, input word_t d, input be_t be,
                                     input prv_t prv, input logic flush, input row_idx_t row);
    word_t res;
    res = old;
    if (flush || (row[ROW_W-1] && prv != PRV_M)) begin
      return old;  // flush or protected row
    end
    for (int b = 0; b < $bits(be_t); b++) begin
      if (be[b]) res[b*8 +: 8] = d[b*8 +: 8];
    end
    return res;
  endfunction

  // sampled mid-cycle, away from the edges
  always @(negedge clk) begin : watch
    bank_idx_t bank;
    row_idx_t  row;
    int        lat;
    logic      wr;
    logic      chk;
    word_t     exp_q;
    if (!rstn) begin
      err_cnt  = 0;
      pend_cnt = 0;
      cycle    = 0;
      req_cycle.delete();
      req_write.delete();
      req_check.delete();
      req_exp.delete();
    end else begin
      cycle++;
      if (mem_ack === 1'b1) begin
        if (req_cycle.size() == 0) begin
          err_cnt++;
          $display("acknowledge in cycle %0d without a request outstanding", cycle);
        end else begin
          lat   = cycle - req_cycle.pop_front();
          wr    = req_write.pop_front();
          chk   = req_check.pop_front();
          exp_q = req_exp.pop_front();
          if (wr && lat != 1) begin  // one outstanding at most, buffer never full
            err_cnt++;
            $display("write acknowledged %0d cycles after its request instead of 1", lat);
          end
          if (chk && mem_q !== exp_q) begin
            err_cnt++;
            $display("error mem_q expected %h actual %h", exp_q, mem_q);
          end
        end
      end else if (mem_ack !== 1'b0) begin
        err_cnt++;
        $display("error mem_ack expected %h actual %h", 1'b0, mem_ack);
      end
      if (mem_req === 1'b1) begin
        bank = mem_adr[2 +: BANK_W];           // above byte offset
        row  = mem_adr[2 + BANK_W +: ROW_W];   // higher bits alias
        req_cycle.push_back(cycle);
        req_write.push_back(mem_we);
        req_check.push_back(~mem_we & ~bu_cacheflush);
        req_exp.push_back(shadow[bank][row]);
        if (mem_we) begin
          shadow[bank][row] = ref_word(shadow[bank][row], mem_d, mem_be, st_prv,
                                       bu_cacheflush, row);
        end
      end
      pend_cnt = req_cycle.size();
    end
  end

endmodule

//--- testbench/tb_mem_subsys.sv
// memory subsystem testbench
// lfsr driven cpu accesses through buffer and banks, checker on the cpu port
`include "wbuf_config.svh"

module tb_mem_subsys import wbuf_pkg::*; ();

  localparam int   ACK_TIMEOUT = 40;  // cycles per access
  localparam int   HI_BIT      = 2 + $bits(bank_idx_t) + $bits(row_idx_t);  // first alias bit
  localparam int   BURST       = `WBUF_DEPTH + 4;
  localparam prv_t PRV_M       = prv_t'(3);

  logic  clk;
  logic  rstn;
  logic  mem_req;
  logic  mem_we;
  word_t mem_adr;
  word_t mem_d;
  be_t   mem_be;
  prv_t  st_prv;
  logic  bu_cacheflush;
  word_t mem_q;
  logic  mem_ack;

  int          timeouts;
  int          err_cnt;
  int          pend_cnt;
  logic [31:0] lfsr;
  word_t       adr_list [BURST];

  mem_subsys_top dut_i (
    .clk, .rstn, .mem_req, .mem_we, .mem_adr, .mem_d, .mem_be, .st_prv,
    .bu_cacheflush, .mem_q, .mem_ack
  );

  mem_checker chk_i (
    .clk, .rstn, .mem_req, .mem_we, .mem_adr, .mem_d, .mem_be, .st_prv,
    .bu_cacheflush, .mem_q, .mem_ack, .err_cnt, .pend_cnt
  );

  always #2 clk = ~clk;

  // galois step, taps x^32 x^22 x^2 x 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
  endfunction

  task automatic rand_bits(input int n, output word_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[`WBUF_XLEN-2:0], lfsr[0]};  // one step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // one cpu access, pulse then wait for the ack
  task automatic access(input logic we, input word_t adr, input word_t d, input be_t be,
                        input prv_t prv, input logic flush);
    int cycles;
    @(posedge clk);
    mem_req       <= 1'b1;
    mem_we        <= we;
    mem_adr       <= adr;
    mem_d         <= d;
    mem_be        <= be;
    st_prv        <= prv;
    bu_cacheflush <= flush;
    @(posedge clk);
    mem_req <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (mem_ack !== 1'b1 && cycles < ACK_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (mem_ack !== 1'b1) begin
      timeouts++;
      $display("no acknowledge within %0d cycles for access to %h", ACK_TIMEOUT, adr);
    end
  endtask

  initial begin : stim
    word_t a;
    word_t d;
    word_t r;
    clk           = 1'b0;
    rstn          = 1'b0;
    mem_req       = 1'b0;
    mem_we        = 1'b0;
    mem_adr       = '0;
    mem_d         = '0;
    mem_be        = '0;
    st_prv        = '0;
    bu_cacheflush = 1'b0;
    lfsr          = 32'h12d4;
    timeouts      = 0;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    repeat (4) @(posedge clk);  // quiet bus, no stray ack

    // fill all rows at machine level
    for (int i = 0; i < `WBUF_BANKS * `WBUF_ROWS; i++) begin
      rand_bits(32, d);
      access(1'b1, word_t'(i) << 2, d, '1, PRV_M, 1'b0);
    end

    //////////////////////////////
    // read after write, then a longer burst than the fifo
    for (int n = 8; n <= BURST; n += BURST - 8) begin
      for (int i = 0; i < n; i++) begin
        rand_bits(32, adr_list[i]);
        rand_bits(32, d);
        rand_bits(4, r);
        access(1'b1, adr_list[i], d, be_t'(r), PRV_M, 1'b0);  // partial bytes
      end
      for (int i = 0; i < n; i++) begin
        access(1'b0, adr_list[i], '0, '0, PRV_M, 1'b0);
      end
    end

    //////////////////////////////
    // privilege on protected half
    for (int i = 0; i < 8; i++) begin
      rand_bits(32, a);
      rand_bits(32, d);
      rand_bits(2, r);
      a[HI_BIT-1] = 1'b1;
      access(1'b1, a, d, '1, prv_t'(r % 3), 1'b0);  // dropped
      access(1'b0, a, '0, '0, PRV_M, 1'b0);
      access(1'b1, a, ~d, '1, PRV_M, 1'b0);         // lands
      access(1'b0, a, '0, '0, PRV_M, 1'b0);
      a[HI_BIT-1] = 1'b0;
      access(1'b1, a, d, '1, prv_t'(r % 3), 1'b0);  // open half
      access(1'b0, a, '0, '0, PRV_M, 1'b0);
    end

    // flushes, as write and as read
    for (int i = 0; i < 6; i++) begin
      rand_bits(32, a);
      rand_bits(32, d);
      access(1'b0, a, '0, '0, PRV_M, 1'b0);
      access(i[0], a, d, '1, PRV_M, 1'b1);
      access(1'b0, a, '0, '0, PRV_M, 1'b0);
    end

    // every bank, read back through aliased high bits
    for (int i = 0; i < 32; i++) begin
      rand_bits(32, a);
      rand_bits(32, d);
      rand_bits(`WBUF_XLEN - HI_BIT, r);
      a[2 +: $bits(bank_idx_t)] = bank_idx_t'(i);
      access(1'b1, a, d, '1, PRV_M, 1'b0);
      access(1'b0, a ^ (r << HI_BIT), '0, '0, PRV_M, 1'b0);
    end

    repeat (3) @(posedge clk);
    $display("errors %0d, missing acks %0d, outstanding %0d", err_cnt, timeouts, pend_cnt);
    if (err_cnt == 0 && timeouts == 0 && pend_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
+incdir+common
common/wbuf_pkg.sv
write_buffer/write_buffer.sv
source/bank_dispatch.sv
source/mem_bank.sv
source/resp_collect.sv
source/mem_subsys_top.sv
testbench/mem_checker.sv
testbench/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/wbuf_pkg.sv
      - write_buffer/write_buffer.sv
      - source/bank_dispatch.sv
      - source/mem_bank.sv
      - source/resp_collect.sv
      - source/mem_subsys_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/mem_checker.sv
      - testbench/tb_mem_subsys.sv
